// File: snake_pkg.sv
package snake_pkg;

    // display geometry
    localparam int NUM_DIGITS = 8;

    // lattice corner coordinates
    typedef logic [3:0] col_t;
    typedef logic [1:0] row_t;

    // one-hot digit enable and segment byte
    typedef logic [NUM_DIGITS-1:0] digit_sel_t;
    typedef logic [7:0] seg_mask_t;

    // scan position within a frame
    typedef logic [$clog2(NUM_DIGITS)-1:0] digit_index_t;

    // direction the head travels in
    typedef enum logic [1:0] {
        heading_up,
        heading_down,
        heading_left,
        heading_right
    } heading_t;

    // lattice limits, columns 0 to 8 and rows 0 to 2
    localparam col_t MAX_COL = 4'd8;
    localparam row_t MAX_ROW = 2'd2;

    // body length in edges
    localparam int SNAKE_LENGTH = 4;

    // cycles between steps, a whole number of frames
    localparam int STEP_PERIOD = 8;
    localparam int STEP_COUNT_WIDTH = $clog2(STEP_PERIOD);

    typedef logic [STEP_COUNT_WIDTH-1:0] step_count_t;

    // head point and heading after reset
    localparam col_t RESET_HEAD_COL = 4'd4;
    localparam row_t RESET_HEAD_ROW = 2'd1;
    localparam heading_t RESET_HEADING = heading_right;

    // bit positions inside seg_mask_t, a set bit lights the segment
    localparam int SEG_A = 0;
    localparam int SEG_B = 1;
    localparam int SEG_C = 2;
    localparam int SEG_D = 3;
    localparam int SEG_E = 4;
    localparam int SEG_F = 5;
    localparam int SEG_G = 6;
    localparam int SEG_DP = 7;

endpackage

// File: body_link_if.sv
interface body_link_if
    import snake_pkg::*;
    ();

    // one-cycle strobe, every stage shifts on it
    logic step;

    // edge start point and orientation
    col_t col;
    row_t row;
    logic vertical;

    modport giver (
        output step,
        output col,
        output row,
        output vertical
    );

    modport taker (
        input step,
        input col,
        input row,
        input vertical
    );

endinterface

// File: steering.sv
module steering
    import snake_pkg::*;
(
    input  logic        clock_10hz,
    input  logic        reset,
    input  logic [3:0]  buttons,
    body_link_if.giver  head_link
);

    step_count_t step_count;
    logic        step_strobe;

    heading_t heading;
    heading_t pending_heading;
    heading_t button_heading;
    logic     button_valid;

    col_t head_col;
    row_t head_row;
    col_t next_col;
    row_t next_row;
    col_t edge_col;
    row_t edge_row;
    logic edge_vertical;

    function automatic heading_t reverse_of(input heading_t h);
        case (h)
            heading_up:    return heading_down;
            heading_down:  return heading_up;
            heading_left:  return heading_right;
            default:       return heading_left;
        endcase
    endfunction

    // only a single pressed button counts
    always_comb begin
        button_valid = 1'b1;
        button_heading = heading_right;
        case (buttons)
            4'b1000: button_heading = heading_up;
            4'b0100: button_heading = heading_down;
            4'b0010: button_heading = heading_left;
            4'b0001: button_heading = heading_right;
            default: button_valid = 1'b0;
        endcase
    end

    assign step_strobe = (step_count == step_count_t'(STEP_PERIOD - 1));

    always_ff @(posedge clock_10hz) begin
        if (!reset) begin
            step_count <= '0;
        end else if (step_strobe) begin
            step_count <= '0;
        end else begin
            step_count <= step_count + 1'b1;
        end
    end

    // reversal is judged against the heading in force
    always_ff @(posedge clock_10hz) begin
        if (!reset) begin
            pending_heading <= RESET_HEADING;
        end else if (button_valid && (button_heading != reverse_of(heading))) begin
            pending_heading <= button_heading;
        end
    end

    // next head point and the edge that move draws
    // positive moves keep the old point, negative ones the new point,
    // which also gives the blank col 8 / row 2 edge on a wrap
    always_comb begin
        next_col = head_col;
        next_row = head_row;
        edge_col = head_col;
        edge_row = head_row;
        edge_vertical = 1'b0;
        case (pending_heading)
            heading_right: begin
                next_col = (head_col == MAX_COL) ? '0 : head_col + 1'b1;
            end
            heading_left: begin
                next_col = (head_col == '0) ? MAX_COL : head_col - 1'b1;
                edge_col = next_col;
            end
            heading_down: begin
                next_row = (head_row == MAX_ROW) ? '0 : head_row + 1'b1;
                edge_vertical = 1'b1;
            end
            default: begin
                next_row = (head_row == '0) ? MAX_ROW : head_row - 1'b1;
                edge_row = next_row;
                edge_vertical = 1'b1;
            end
        endcase
    end

    always_ff @(posedge clock_10hz) begin
        if (!reset) begin
            heading <= RESET_HEADING;
            head_col <= RESET_HEAD_COL;
            head_row <= RESET_HEAD_ROW;
        end else if (step_strobe) begin
            heading <= pending_heading;
            head_col <= next_col;
            head_row <= next_row;
        end
    end

    assign head_link.step = step_strobe;
    assign head_link.col = edge_col;
    assign head_link.row = edge_row;
    assign head_link.vertical = edge_vertical;

endmodule

// File: body_segment.sv
module body_segment
    import snake_pkg::*;
#(
    parameter int position = 0
)
(
    input  logic        clock_10hz,
    input  logic        reset,
    body_link_if.taker  upstream,
    body_link_if.giver  downstream
);

    // straight run to the left of the reset head
    localparam col_t RESET_COL = col_t'(int'(RESET_HEAD_COL) - 1 - position);

    col_t stored_col;
    row_t stored_row;
    logic stored_vertical;

    always_ff @(posedge clock_10hz) begin
        if (!reset) begin
            stored_col <= RESET_COL;
            stored_row <= RESET_HEAD_ROW;
            stored_vertical <= 1'b0;
        end else if (upstream.step) begin
            stored_col <= upstream.col;
            stored_row <= upstream.row;
            stored_vertical <= upstream.vertical;
        end
    end

    // strobe goes on unregistered so the whole chain shifts together
    assign downstream.step = upstream.step;
    assign downstream.col = stored_col;
    assign downstream.row = stored_row;
    assign downstream.vertical = stored_vertical;

endmodule

// File: segment_scanner.sv
module segment_scanner
    import snake_pkg::*;
(
    input  logic       clock_10hz,
    input  logic       reset,
    input  col_t       body_cols [SNAKE_LENGTH],
    input  row_t       body_rows [SNAKE_LENGTH],
    input  logic       body_verticals [SNAKE_LENGTH],
    output digit_sel_t digit_enable,
    output seg_mask_t  segments
);

    digit_index_t digit_index;
    col_t         digit_col;
    col_t         digit_col_right;
    seg_mask_t    seg_mask;

    // wrap edges sit where no segment exists
    function automatic logic edge_is_blank(input col_t c, input row_t r, input logic v);
        return (!v && (c == MAX_COL)) || (v && (r == MAX_ROW));
    endfunction

    always_ff @(posedge clock_10hz) begin
        if (!reset) begin
            digit_index <= '0;
        end else if (digit_index == digit_index_t'(NUM_DIGITS - 1)) begin
            digit_index <= '0;
        end else begin
            digit_index <= digit_index + 1'b1;
        end
    end

    assign digit_enable = digit_sel_t'(1) << digit_index;

    // left and right corner columns of the selected digit
    assign digit_col = {1'b0, digit_index};
    assign digit_col_right = digit_col + 1'b1;

    always_comb begin
        seg_mask = '0;
        for (int i = 0; i < SNAKE_LENGTH; i++) begin
            if (!body_verticals[i]) begin
                // top, middle and bottom bars
                if (body_cols[i] == digit_col) begin
                    if (body_rows[i] == 2'd0) begin
                        seg_mask[SEG_A] = 1'b1;
                    end else if (body_rows[i] == 2'd1) begin
                        seg_mask[SEG_G] = 1'b1;
                    end else if (body_rows[i] == 2'd2) begin
                        seg_mask[SEG_D] = 1'b1;
                    end
                end
            end else if (body_rows[i] == 2'd0) begin
                // upper half, left side f and right side b
                if (body_cols[i] == digit_col) begin
                    seg_mask[SEG_F] = 1'b1;
                end
                if (body_cols[i] == digit_col_right) begin
                    seg_mask[SEG_B] = 1'b1;
                end
            end else if (body_rows[i] == 2'd1) begin
                // lower half, e and c
                if (body_cols[i] == digit_col) begin
                    seg_mask[SEG_E] = 1'b1;
                end
                if (body_cols[i] == digit_col_right) begin
                    seg_mask[SEG_C] = 1'b1;
                end
            end
        end

        // dp marks the digit where the newest edge starts
        if (!edge_is_blank(body_cols[0], body_rows[0], body_verticals[0])
                && (body_cols[0] == digit_col)) begin
            seg_mask[SEG_DP] = 1'b1;
        end
    end

    assign segments = seg_mask;

endmodule

// File: snake_display_top.sv
module snake_display_top
    import snake_pkg::*;
(
    input  logic       clock_10hz,
    input  logic       reset,
    input  logic [3:0] buttons,
    output digit_sel_t digit_enable,
    output seg_mask_t  segments
);

    // link 0 is the head edge, link SNAKE_LENGTH is the dropped tail
    body_link_if links [SNAKE_LENGTH+1] ();

    col_t body_cols [SNAKE_LENGTH];
    row_t body_rows [SNAKE_LENGTH];
    logic body_verticals [SNAKE_LENGTH];

    steering steering_inst (
        .clock_10hz (clock_10hz),
        .reset      (reset),
        .buttons    (buttons),
        .head_link  (links[0])
    );

    generate
        for (genvar p = 0; p < SNAKE_LENGTH; p++) begin : gen_body
            body_segment #(
                .position (p)
            ) body_segment_inst (
                .clock_10hz (clock_10hz),
                .reset      (reset),
                .upstream   (links[p]),
                .downstream (links[p+1])
            );

            // stored edge as seen on the outgoing link
            assign body_cols[p] = links[p+1].col;
            assign body_rows[p] = links[p+1].row;
            assign body_verticals[p] = links[p+1].vertical;
        end
    endgenerate

    segment_scanner segment_scanner_inst (
        .clock_10hz     (clock_10hz),
        .reset          (reset),
        .body_cols      (body_cols),
        .body_rows      (body_rows),
        .body_verticals (body_verticals),
        .digit_enable   (digit_enable),
        .segments       (segments)
    );

endmodule

// File: snake_tb.sv
module snake_tb
    import snake_pkg::*;
    ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int FRAME_TIMEOUT = 32;
    localparam logic [3:0] BTN_NONE = 4'b0000;
    localparam logic [3:0] BTN_UP = 4'b1000;
    localparam logic [3:0] BTN_DOWN = 4'b0100;
    localparam logic [3:0] BTN_LEFT = 4'b0010;

    logic       clock_10hz = 1'b0;
    logic       reset;
    logic [3:0] buttons;
    digit_sel_t digit_enable;
    seg_mask_t  segments;

    // last captured frame and the model's prediction for it
    seg_mask_t frame_seen [NUM_DIGITS];
    seg_mask_t frame_expected [NUM_DIGITS];

    // cycles spent waiting for digit 0 before the last frame
    int frame_wait;

    // reference model state
    col_t     model_head_col;
    row_t     model_head_row;
    heading_t model_heading;
    heading_t model_pending;
    col_t     model_col [SNAKE_LENGTH];
    row_t     model_row [SNAKE_LENGTH];
    logic     model_vert [SNAKE_LENGTH];

    logic [31:0] rng_state = 32'h16f8;

    snake_display_top snake_display_top_inst (
        .clock_10hz   (clock_10hz),
        .reset        (reset),
        .buttons      (buttons),
        .digit_enable (digit_enable),
        .segments     (segments)
    );

    always #4 clock_10hz = ~clock_10hz;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_digit_enable(input digit_sel_t actual, input digit_sel_t expected);
        if (actual !== expected) begin
            $display("FAIL digit_enable: got %h expected %h", actual, expected);
            abort_run();
        end
    endtask

    task automatic check_segments(input seg_mask_t actual, input seg_mask_t expected,
                                  input int digit);
        if (actual !== expected) begin
            $display("FAIL segments digit %0d: got %h expected %h", digit, actual, expected);
            abort_run();
        end
    endtask

    // frames follow each other, so digit 0 is due on the first sampled cycle
    task automatic check_frame_start();
        if (frame_wait != 0) begin
            $display("digit 0 was selected %0d cycles later than expected", frame_wait);
            abort_run();
        end
    endtask

    // straight horizontal run on row 1 from tail digit to head digit
    function automatic seg_mask_t middle_run_digit(input int d, input int tail, input int head);
        seg_mask_t m;
        m = 8'h00;
        if (d >= tail && d <= head) begin
            m[SEG_G] = 1'b1;
        end
        if (d == head) begin
            m[SEG_DP] = 1'b1;
        end
        return m;
    endfunction

    function automatic logic is_reverse(input heading_t a, input heading_t b);
        return (a == heading_up && b == heading_down) || (a == heading_down && b == heading_up)
            || (a == heading_left && b == heading_right)
            || (a == heading_right && b == heading_left);
    endfunction

    task automatic model_reset();
        model_head_col = 4'd4;
        model_head_row = 2'd1;
        model_heading = heading_right;
        model_pending = heading_right;
        for (int p = 0; p < SNAKE_LENGTH; p++) begin
            model_col[p] = col_t'(3 - p);
            model_row[p] = 2'd1;
            model_vert[p] = 1'b0;
        end
    endtask

    // press judged against the heading in force
    task automatic model_press(input logic [3:0] pattern);
        heading_t h;
        logic     single;
        single = 1'b1;
        h = heading_right;
        case (pattern)
            BTN_UP: h = heading_up;
            BTN_DOWN: h = heading_down;
            BTN_LEFT: h = heading_left;
            4'b0001: h = heading_right;
            default: single = 1'b0;
        endcase
        if (single && !is_reverse(h, model_heading)) begin
            model_pending = h;
        end
    endtask

    task automatic model_step();
        col_t new_col;
        row_t new_row;
        col_t e_col;
        row_t e_row;
        logic e_vert;
        model_heading = model_pending;
        new_col = model_head_col;
        new_row = model_head_row;
        e_col = model_head_col;
        e_row = model_head_row;
        e_vert = 1'b0;
        case (model_heading)
            heading_right: new_col = (model_head_col == 4'd8) ? 4'd0 : model_head_col + 4'd1;
            heading_left: begin
                new_col = (model_head_col == 4'd0) ? 4'd8 : model_head_col - 4'd1;
                e_col = new_col;
            end
            heading_down: begin
                new_row = (model_head_row == 2'd2) ? 2'd0 : model_head_row + 2'd1;
                e_vert = 1'b1;
            end
            default: begin
                new_row = (model_head_row == 2'd0) ? 2'd2 : model_head_row - 2'd1;
                e_row = new_row;
                e_vert = 1'b1;
            end
        endcase
        // tail drops off, newest edge enters at position 0
        for (int p = SNAKE_LENGTH - 1; p > 0; p--) begin
            model_col[p] = model_col[p-1];
            model_row[p] = model_row[p-1];
            model_vert[p] = model_vert[p-1];
        end
        model_col[0] = e_col;
        model_row[0] = e_row;
        model_vert[0] = e_vert;
        model_head_col = new_col;
        model_head_row = new_row;
    endtask

    task automatic build_expected();
        int   c;
        logic blank;
        for (int d = 0; d < NUM_DIGITS; d++) begin
            frame_expected[d] = 8'h00;
        end
        for (int i = 0; i < SNAKE_LENGTH; i++) begin
            c = int'(model_col[i]);
            if (!model_vert[i]) begin
                if (c < NUM_DIGITS) begin
                    case (model_row[i])
                        2'd0: frame_expected[c][SEG_A] = 1'b1;
                        2'd1: frame_expected[c][SEG_G] = 1'b1;
                        default: frame_expected[c][SEG_D] = 1'b1;
                    endcase
                end
            end else if (model_row[i] != 2'd2) begin
                // left side of digit c, right side of digit c-1
                if (c < NUM_DIGITS) begin
                    if (model_row[i] == 2'd0) frame_expected[c][SEG_F] = 1'b1;
                    else frame_expected[c][SEG_E] = 1'b1;
                end
                if (c > 0) begin
                    if (model_row[i] == 2'd0) frame_expected[c-1][SEG_B] = 1'b1;
                    else frame_expected[c-1][SEG_C] = 1'b1;
                end
            end
        end
        c = int'(model_col[0]);
        blank = model_vert[0] ? (model_row[0] == 2'd2) : (c == 8);
        if (!blank && c < NUM_DIGITS) begin
            frame_expected[c][SEG_DP] = 1'b1;
        end
    endtask

    task automatic reset_dut();
        @(posedge clock_10hz);
        #1;
        reset = 1'b0;
        buttons = BTN_NONE;
        repeat (5) @(posedge clock_10hz);
        #1;
        reset = 1'b1;
        model_reset();
    endtask

    // one frame from digit 0 to digit 7, presses held in the digit 1 and 3 cycles
    task automatic capture_frame(input logic [3:0] first_press, input logic [3:0] second_press);
        int waited;
        waited = 0;
        @(negedge clock_10hz);
        while (digit_enable !== 8'h01) begin
            if (waited == FRAME_TIMEOUT) begin
                $display("timed out waiting for digit 0 to be selected");
                abort_run();
            end
            waited++;
            @(negedge clock_10hz);
        end
        frame_wait = waited;
        for (int d = 0; d < NUM_DIGITS; d++) begin
            if (d > 0) begin
                @(posedge clock_10hz);
                #1;
                if (d == 1) buttons = first_press;
                else if (d == 3) buttons = second_press;
                else buttons = BTN_NONE;
                @(negedge clock_10hz);
                check_digit_enable(digit_enable, digit_sel_t'(1) << d);
            end
            frame_seen[d] = segments;
        end
    endtask

    task automatic run_frame(input logic [3:0] first_press, input logic [3:0] second_press);
        capture_frame(first_press, second_press);
        build_expected();
        for (int d = 0; d < NUM_DIGITS; d++) begin
            check_segments(frame_seen[d], frame_expected[d], d);
        end
        model_press(first_press);
        model_press(second_press);
        model_step();
    endtask

    function automatic int count_lit();
        int n;
        n = 0;
        for (int d = 0; d < NUM_DIGITS; d++) begin
            for (int b = 0; b < SEG_DP; b++) begin
                if (frame_seen[d][b]) n++;
            end
        end
        return n;
    endfunction

    task automatic test_reset_frame();
        reset_dut();
        run_frame(BTN_NONE, BTN_NONE);
        check_frame_start();
        for (int d = 0; d < NUM_DIGITS; d++) begin
            check_segments(frame_seen[d], middle_run_digit(d, 0, 3), d);
        end
        // second frame shows the scan repeating
        run_frame(BTN_NONE, BTN_NONE);
        check_frame_start();
    endtask

    task automatic test_straight_run();
        int lit_expected;
        reset_dut();
        for (int k = 0; k <= 12; k++) begin
            run_frame(BTN_NONE, BTN_NONE);
            // wrap edge is blank while it is in the body
            lit_expected = (k == 9) ? 4 : 3;
            if (k >= 5 && k <= 9 && count_lit() != lit_expected) begin
                $display("FAIL lit body segments in frame %0d: got %h expected %h",
                         k, count_lit(), lit_expected);
                abort_run();
            end
        end
    endtask

    task automatic test_turns();
        reset_dut();
        run_frame(BTN_NONE, BTN_NONE);
        run_frame(BTN_DOWN, BTN_NONE);
        run_frame(BTN_LEFT, BTN_NONE);
        run_frame(BTN_UP, BTN_NONE);
        run_frame(BTN_NONE, BTN_NONE);
        run_frame(BTN_NONE, BTN_NONE);
        // column 4 upper edge lights f on digit 4 and b on digit 3
        check_segments(frame_seen[4] & 8'h20, 8'h20, 4);
        check_segments(frame_seen[3] & 8'h02, 8'h02, 3);
        for (int k = 0; k < 3; k++) begin
            run_frame(BTN_NONE, BTN_NONE);
        end
    endtask

    task automatic test_ignored_presses();
        reset_dut();
        run_frame(BTN_LEFT, 4'b1001);
        run_frame(4'b1100, BTN_LEFT);
        run_frame(4'b0011, 4'b1111);
        run_frame(BTN_LEFT, BTN_LEFT);
        run_frame(BTN_NONE, BTN_NONE);
        for (int d = 0; d < NUM_DIGITS; d++) begin
            check_segments(frame_seen[d], middle_run_digit(d, 4, 7), d);
        end
    endtask

    task automatic test_last_press_wins();
        reset_dut();
        run_frame(BTN_UP, BTN_DOWN);
        for (int k = 1; k < 30; k++) begin
            rng_state = xorshift(rng_state);
            run_frame(rng_state[3:0], rng_state[7:4]);
        end
        run_frame(BTN_NONE, BTN_NONE);
        // a fresh reset brings back frame 0
        reset_dut();
        capture_frame(BTN_NONE, BTN_NONE);
        for (int d = 0; d < NUM_DIGITS; d++) begin
            check_segments(frame_seen[d], middle_run_digit(d, 0, 3), d);
        end
    endtask

    initial begin
        reset = 1'b0;
        buttons = BTN_NONE;
        test_reset_frame();
        test_straight_run();
        test_turns();
        test_ignored_presses();
        test_last_press_wins();
        $display("PASS: all tests");
        $finish;
    end

endmodule

// File: vlog.f
snake_pkg.sv
body_link_if.sv
steering.sv
body_segment.sv
segment_scanner.sv
snake_display_top.sv
snake_tb.sv

// File: Makefile
TOOL      = verilator
FLAGS     = --binary --timing --timescale 1ns/100ps
TOP       = snake_tb
FILE_LIST = vlog.f

OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
FAIL_MSG  = FAIL: see errors above
PASS_MSG  = PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILE_LIST)

run: compile
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
